// ==== design/vicii_params.svh ====
`ifndef VICII_PARAMS_SVH
`define VICII_PARAMS_SVH

// raster geometry, one dot every four clk_dot4x
`define VIC_DOTS_PER_LINE 504   // dots per line
`define VIC_LINES         312   // lines per frame

// sync windows, x or y below the value
`define VIC_HSYNC_END     40
`define VIC_VSYNC_END     3

// active picture including border, lower bound in, upper bound out
`define VIC_ACT_X0        64
`define VIC_ACT_X1        464
`define VIC_ACT_Y0        16
`define VIC_ACT_Y1        296

// display window where background shows
`define VIC_DISP_X0       104
`define VIC_DISP_X1       424
`define VIC_DISP_Y0       51
`define VIC_DISP_Y1       251

// register map, 6 bit cpu address
`define VIC_REG_CTRL      6'h11   // bit 7 is raster bit 8
`define VIC_REG_RASTER    6'h12   // raster bits 7:0
`define VIC_REG_IRQ       6'h19   // irq status, w1c on bit 0
`define VIC_REG_IRQEN     6'h1A   // irq enable
`define VIC_REG_BORDER    6'h20   // border colour
`define VIC_REG_BG0       6'h21   // background colour 0

`endif

// ==== design/vicii_pkg.sv ====
`default_nettype none

// shared types for the lite video chip
package vicii_pkg;

   // palette index, 16 colours
   typedef logic [3:0] color_t;

   // one analog colour component
   typedef logic [5:0] rgb6_t;

   // line number, up to 312 lines
   typedef logic [8:0] raster_t;

   // dot number within a line, up to 504 dots
   typedef logic [8:0] xpos_t;

   // cpu register address, low 6 bits of the bus
   typedef logic [5:0] reg_addr_t;

endpackage

`default_nettype wire

// ==== design/reg_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vicii_params.svh"

module reg_bus
   import vicii_pkg::*;
(
   input  logic       clk_dot4x,
   input  logic       rst,
   input  reg_addr_t  adi,         // register select
   input  logic [7:0] dbi,         // write data from cpu
   input  logic       ce,          // low while chip selected
   input  logic       rw,          // high = read
   input  raster_t    raster_y,    // current line from timing
   input  logic       cmp_hit,     // new line matches compare
   output logic [7:0] dbo,         // read data, zero when idle
   output logic       irq,         // level, active high
   output raster_t    raster_cmp,  // 9 bit compare value
   output color_t     border_col,
   output color_t     bg_col
);

   logic       ce_d;         // ce from last clock
   logic       acc_start;    // first clock of an access
   logic       wr_stb;       // write strobe, one clock
   logic       raster_flag;  // raster irq status
   logic       irq_en;       // raster irq enable
   logic [7:0] rd_data;

   // access begins on first edge with ce low after high
   assign acc_start = ce_d & ~ce;
   assign wr_stb    = acc_start & ~rw;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ce_d <= 1'b1;  // bus idle
      end else begin
         ce_d <= ce;
      end
   end

   // register writes
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         border_col <= '0;
         bg_col     <= '0;
         raster_cmp <= '0;
         irq_en     <= 1'b0;
      end else if (wr_stb) begin
         case (adi)
            `VIC_REG_CTRL:   raster_cmp[8]   <= dbi[7];
            `VIC_REG_RASTER: raster_cmp[7:0] <= dbi;
            `VIC_REG_IRQEN:  irq_en          <= dbi[0];
            `VIC_REG_BORDER: border_col      <= dbi[3:0];
            `VIC_REG_BG0:    bg_col          <= dbi[3:0];
            default: ;  // unused address, write dropped
         endcase
      end
   end

   // raster flag: set on compare hit, cleared by writing 1 to bit 0
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_flag <= 1'b0;
      end else if (cmp_hit) begin
         raster_flag <= 1'b1;  // a new match wins over a clear
      end else if (wr_stb && adi == `VIC_REG_IRQ && dbi[0]) begin
         raster_flag <= 1'b0;
      end
   end

   // irq is registered, lags flag or enable by one clock
   always_ff @(posedge clk_dot4x) begin
      if (rst) irq <= 1'b0;
      else     irq <= raster_flag & irq_en;
   end

   // read mux
   always_comb begin
      case (adi)
         `VIC_REG_CTRL:   rd_data = {raster_y[8], 7'b0000000};
         `VIC_REG_RASTER: rd_data = raster_y[7:0];
         `VIC_REG_IRQ:    rd_data = {irq, 6'b111111, raster_flag};
         `VIC_REG_IRQEN:  rd_data = {7'b1111111, irq_en};
         `VIC_REG_BORDER: rd_data = {4'hF, border_col};  // upper nibble reads 1
         `VIC_REG_BG0:    rd_data = {4'hF, bg_col};
         default:         rd_data = 8'hFF;
      endcase
   end

   assign dbo = (~ce & rw) ? rd_data : 8'h00;  // drive only on a read

   // interrupt must not assert with the enable low in the previous clock
   a_irq_needs_en : assert property (@(posedge clk_dot4x) disable iff (rst)
      $rose(irq) |-> $past(irq_en));

   // bus stays quiet when not selected
   a_dbo_idle : assert property (@(posedge clk_dot4x)
      ce |-> (dbo == 8'h00));

endmodule

`default_nettype wire

// ==== design/raster_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vicii_params.svh"

module raster_timing
   import vicii_pkg::*;
(
   input  logic    clk_dot4x,
   input  logic    rst,
   input  raster_t raster_cmp,  // compare line from reg_bus
   output logic    dot_en,      // one clock in four
   output logic    line_start,  // x wraps to 0
   output raster_t raster_y,    // current line
   output logic    hsync_i,
   output logic    vsync_i,
   output logic    active_i,    // picture incl border
   output logic    disp_i,      // display window
   output logic    cmp_hit      // line start onto compare line
);

   logic [1:0] phase;    // clock within the dot
   xpos_t      x;        // current dot
   raster_t    y_next;   // line after the current one
   logic       line_end;
   logic       act_x;
   logic       act_y;
   logic       disp_x;
   logic       disp_y;

   assign dot_en     = (phase == 2'd3);
   assign line_end   = (x == xpos_t'(`VIC_DOTS_PER_LINE - 1));
   assign line_start = dot_en & line_end;  // same cycle the wrap is taken

   // next line, wraps at end of frame
   assign y_next = (raster_y == raster_t'(`VIC_LINES - 1)) ? '0 : raster_y + 1'b1;

   // match against the line about to start
   assign cmp_hit = line_start & (y_next == raster_cmp);

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phase    <= '0;
         x        <= '0;
         raster_y <= '0;
      end else begin
         phase <= phase + 2'd1;  // free running, wraps at 4
         if (dot_en) begin
            if (line_end) begin
               x        <= '0;
               raster_y <= y_next;
            end else begin
               x <= x + 1'b1;
            end
         end
      end
   end

   // window decode, lower bound in, upper bound out
   assign hsync_i = (x < xpos_t'(`VIC_HSYNC_END));
   assign vsync_i = (raster_y < raster_t'(`VIC_VSYNC_END));

   assign act_x = (x >= xpos_t'(`VIC_ACT_X0)) && (x < xpos_t'(`VIC_ACT_X1));
   assign act_y = (raster_y >= raster_t'(`VIC_ACT_Y0)) &&
                  (raster_y < raster_t'(`VIC_ACT_Y1));
   assign active_i = act_x & act_y;

   assign disp_x = (x >= xpos_t'(`VIC_DISP_X0)) && (x < xpos_t'(`VIC_DISP_X1));
   assign disp_y = (raster_y >= raster_t'(`VIC_DISP_Y0)) &&
                   (raster_y < raster_t'(`VIC_DISP_Y1));
   assign disp_i = disp_x & disp_y;  // always inside the active window

   // dot counter never runs past the line
   a_x_in_line : assert property (@(posedge clk_dot4x) disable iff (rst)
      x < xpos_t'(`VIC_DOTS_PER_LINE));

   // new line only ever starts on a dot boundary
   a_line_on_dot : assert property (@(posedge clk_dot4x) disable iff (rst)
      line_start |-> dot_en);

endmodule

`default_nettype wire

// ==== design/pixel_out.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vicii_params.svh"

module pixel_out
   import vicii_pkg::*;
(
   input  logic   clk_dot4x,
   input  logic   rst,
   input  logic   dot_en,      // register on this clock
   input  logic   hsync_i,
   input  logic   vsync_i,
   input  logic   active_i,
   input  logic   disp_i,      // background inside, border outside
   input  color_t border_col,
   input  color_t bg_col,
   output rgb6_t  red,
   output rgb6_t  green,
   output rgb6_t  blue,
   output logic   hsync,
   output logic   vsync,
   output logic   active
);

   color_t      col_sel;  // index for this dot
   logic [17:0] rgb;      // {r, g, b} from palette

   // 6 bit palette close to the original chip colours
   function automatic logic [17:0] pal_lookup(input color_t c);
      case (c)
         4'd0:    pal_lookup = {6'h00, 6'h00, 6'h00};  // black
         4'd1:    pal_lookup = {6'h3F, 6'h3F, 6'h3F};  // white
         4'd2:    pal_lookup = {6'h1A, 6'h0D, 6'h0A};  // red
         4'd3:    pal_lookup = {6'h1C, 6'h29, 6'h2C};  // cyan
         4'd4:    pal_lookup = {6'h1B, 6'h0F, 6'h21};  // purple
         4'd5:    pal_lookup = {6'h16, 6'h23, 6'h10};  // green
         4'd6:    pal_lookup = {6'h0D, 6'h0A, 6'h1E};  // blue
         4'd7:    pal_lookup = {6'h2E, 6'h31, 6'h1B};  // yellow
         4'd8:    pal_lookup = {6'h1B, 6'h13, 6'h09};  // orange
         4'd9:    pal_lookup = {6'h10, 6'h0E, 6'h00};  // brown
         4'd10:   pal_lookup = {6'h26, 6'h19, 6'h16};  // light red
         4'd11:   pal_lookup = {6'h11, 6'h11, 6'h11};  // dark grey
         4'd12:   pal_lookup = {6'h1B, 6'h1B, 6'h1B};  // mid grey
         4'd13:   pal_lookup = {6'h26, 6'h34, 6'h21};  // light green
         4'd14:   pal_lookup = {6'h1B, 6'h17, 6'h2D};  // light blue
         default: pal_lookup = {6'h25, 6'h25, 6'h25};  // light grey
      endcase
   endfunction

   assign col_sel = disp_i ? bg_col : border_col;
   assign rgb     = pal_lookup(col_sel);

   // one register stage per dot, blank outside the active picture
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         red    <= '0;
         green  <= '0;
         blue   <= '0;
         hsync  <= 1'b0;
         vsync  <= 1'b0;
         active <= 1'b0;
      end else if (dot_en) begin
         red    <= active_i ? rgb[17:12] : '0;
         green  <= active_i ? rgb[11:6]  : '0;
         blue   <= active_i ? rgb[5:0]   : '0;
         hsync  <= hsync_i;  // syncs ride with the colour
         vsync  <= vsync_i;
         active <= active_i;
      end
   end

endmodule

`default_nettype wire

// ==== design/vicii_lite.sv ====
`timescale 1ns/1ps
`default_nettype none

module vicii_lite
   import vicii_pkg::*;
(
   input  logic       clk_dot4x,
   input  logic       rst,
   input  reg_addr_t  adi,    // cpu address, low 6 bits
   input  logic [7:0] dbi,    // cpu write data
   input  logic       ce,     // chip select, active low
   input  logic       rw,     // high = read
   output logic [7:0] dbo,    // cpu read data
   output logic       irq,
   output rgb6_t      red,
   output rgb6_t      green,
   output rgb6_t      blue,
   output logic       hsync,
   output logic       vsync,
   output logic       active
);

   raster_t raster_y;    // current line
   raster_t raster_cmp;  // compare line
   logic    cmp_hit;
   logic    dot_en;
   logic    hsync_i;
   logic    vsync_i;
   logic    active_i;
   logic    disp_i;
   color_t  border_col;
   color_t  bg_col;

   // cpu side registers and irq
   reg_bus u_reg_bus (
      .clk_dot4x  (clk_dot4x),
      .rst        (rst),
      .adi        (adi),
      .dbi        (dbi),
      .ce         (ce),
      .rw         (rw),
      .raster_y   (raster_y),
      .cmp_hit    (cmp_hit),
      .dbo        (dbo),
      .irq        (irq),
      .raster_cmp (raster_cmp),
      .border_col (border_col),
      .bg_col     (bg_col)
   );

   // counters and windows, line_start only feeds cmp_hit inside
   raster_timing u_timing (
      .clk_dot4x  (clk_dot4x),
      .rst        (rst),
      .raster_cmp (raster_cmp),
      .dot_en     (dot_en),
      .line_start (),
      .raster_y   (raster_y),
      .hsync_i    (hsync_i),
      .vsync_i    (vsync_i),
      .active_i   (active_i),
      .disp_i     (disp_i),
      .cmp_hit    (cmp_hit)
   );

   pixel_out u_pixel (
      .clk_dot4x  (clk_dot4x),
      .rst        (rst),
      .dot_en     (dot_en),
      .hsync_i    (hsync_i),
      .vsync_i    (vsync_i),
      .active_i   (active_i),
      .disp_i     (disp_i),
      .border_col (border_col),
      .bg_col     (bg_col),
      .red        (red),
      .green      (green),
      .blue       (blue),
      .hsync      (hsync),
      .vsync      (vsync),
      .active     (active)
   );

endmodule

`default_nettype wire

// ==== dv/vicii_lite_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vicii_params.svh"

module vicii_lite_tb
   import vicii_pkg::*;
();

   localparam int frame_clocks = 4 * `VIC_DOTS_PER_LINE * `VIC_LINES;
   localparam int cycle_limit  = 3 * frame_clocks + 1000;  // two frames of reads plus irq tests

   // reference palette, {r, g, b} at 6 bits each
   localparam logic [17:0] palette [16] = '{
      18'h00000, 18'h3FFFF, 18'h1A34A, 18'h1CA6C,
      18'h1B3E1, 18'h168D0, 18'h0D29E, 18'h2EC5B,
      18'h1B4C9, 18'h10380, 18'h26656, 18'h11451,
      18'h1B6DB, 18'h26D21, 18'h1B5ED, 18'h25965};

   logic       clk_dot4x = 1'b0;
   logic       rst;
   reg_addr_t  adi;
   logic [7:0] dbi;
   logic       ce;
   logic       rw;
   logic [7:0] dbo;
   logic       irq;
   rgb6_t      red, green, blue;
   logic       hsync, vsync, active;

   logic [31:0] lfsr = 32'h8963_4780;
   int          cyc = 0;          // clocks since reset release
   int          run_cycles = 0;
   int          bus_errors = 0;
   int          video_errors = 0;
   color_t      sh_border = '0;   // expected register contents
   color_t      sh_bg = '0;
   logic        sh_en = 1'b0;
   color_t      snap_border = '0; // colours in effect at the last edge
   color_t      snap_bg = '0;
   int          px;
   int          py;

   vicii_lite dut (.*);

   function automatic int dot_x(input int c);
      return (c / 4) % `VIC_DOTS_PER_LINE;
   endfunction

   function automatic int line_y(input int c);
      return (c / (4 * `VIC_DOTS_PER_LINE)) % `VIC_LINES;
   endfunction

   // galois lfsr, one step per bit
   function automatic logic [7:0] rand_bits(input int n);
      logic [7:0] v;
      v = 8'h00;
      for (int i = 0; i < n; i++) begin
         v    = {v[6:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return v;
   endfunction

   function automatic logic in_active(input int x, input int y);
      return (x >= `VIC_ACT_X0) && (x < `VIC_ACT_X1) && (y >= `VIC_ACT_Y0) && (y < `VIC_ACT_Y1);
   endfunction

   function automatic logic in_disp(input int x, input int y);
      return (x >= `VIC_DISP_X0) && (x < `VIC_DISP_X1) && (y >= `VIC_DISP_Y0) &&
             (y < `VIC_DISP_Y1);
   endfunction

   function automatic logic [17:0] expected_rgb(input int x, input int y,
                                                input color_t bord, input color_t bg);
      return in_active(x, y) ? palette[in_disp(x, y) ? bg : bord] : 18'd0;
   endfunction

   // read value per register, flag and irq given by the caller
   function automatic logic [7:0] reg_value(input reg_addr_t a, input raster_t y,
                                            input logic flag, input logic irqv);
      case (a)
         `VIC_REG_CTRL:   return {y[8], 7'b0000000};
         `VIC_REG_RASTER: return y[7:0];
         `VIC_REG_IRQ:    return {irqv, 6'b111111, flag};
         `VIC_REG_IRQEN:  return {7'b1111111, sh_en};
         `VIC_REG_BORDER: return {4'hF, sh_border};
         `VIC_REG_BG0:    return {4'hF, sh_bg};
         default:         return 8'hFF;
      endcase
   endfunction

   // compare target a few lines ahead of the current one
   function automatic int pick_line();
      logic [7:0] off;
      off = rand_bits(4);
      return (line_y(cyc) + 2 + int'(off)) % `VIC_LINES;
   endfunction

   task automatic compare(input logic ok, input string what, inout int errs);
      assert (ok) else begin
         errs++;
         $display("Error at %0t: %s", $time, what);
      end
   endtask

   task automatic release_bus();
      @(negedge clk_dot4x);
      ce = 1'b1;  // second clock low done
      rw = 1'b1;
      @(negedge clk_dot4x);
   endtask

   task automatic bus_write(input reg_addr_t a, input logic [7:0] d);
      @(negedge clk_dot4x);
      adi = a;
      dbi = d;
      rw  = 1'b0;
      ce  = 1'b0;
      @(posedge clk_dot4x);  // write lands on this edge
      if (a == `VIC_REG_BORDER) sh_border = d[3:0];
      if (a == `VIC_REG_BG0) sh_bg = d[3:0];
      if (a == `VIC_REG_IRQEN) sh_en = d[0];
      @(negedge clk_dot4x);
      release_bus();
   endtask

   task automatic read_check(input reg_addr_t a, input logic flag, input logic irqv);
      logic [7:0] want;
      @(negedge clk_dot4x);
      adi = a;
      rw  = 1'b1;
      ce  = 1'b0;
      @(negedge clk_dot4x);
      want = reg_value(a, raster_t'(line_y(cyc)), flag, irqv);
      compare(dbo == want, $sformatf("read %h gave %h, expected %h", a, dbo, want), bus_errors);
      release_bus();
   endtask

   task automatic set_compare(input int line_no);
      raster_t l;
      l = raster_t'(line_no);
      bus_write(`VIC_REG_RASTER, l[7:0]);
      bus_write(`VIC_REG_CTRL, {l[8], 7'b0000000});
      bus_write(`VIC_REG_IRQ, 8'h01);  // drop any earlier hit
   endtask

   task automatic apply_reset();
      rst = 1'b1;
      repeat (4) @(posedge clk_dot4x);
      sh_border = '0;
      sh_bg     = '0;
      sh_en     = 1'b0;
      @(negedge clk_dot4x);
      compare(irq == 1'b0 && dbo == 8'h00, "irq or dbo not cleared by reset", bus_errors);
      rst = 1'b0;
   endtask

   initial begin
      forever #5 clk_dot4x = ~clk_dot4x;
   end

   always @(posedge clk_dot4x) begin
      if (rst) cyc <= 0;
      else     cyc <= cyc + 1;
   end

   always @(posedge clk_dot4x) begin
      run_cycles <= run_cycles + 1;
      if (run_cycles == cycle_limit) begin
         $display("timeout, tests still running after %0d clock cycles", cycle_limit);
         $display("TEST FAILED");
         $finish;
      end
   end

   // video compare, outputs describe the dot of the previous dot_en
   always @(negedge clk_dot4x) begin
      if (cyc < 4) begin
         compare({red, green, blue, hsync, vsync, active} == 21'd0,
                 "video outputs not at reset value", video_errors);
      end else if (cyc % 4 == 0) begin
         px = dot_x(cyc - 4);
         py = line_y(cyc - 4);
         compare({red, green, blue} == expected_rgb(px, py, snap_border, snap_bg),
                 $sformatf("rgb %h at x %0d y %0d", {red, green, blue}, px, py), video_errors);
         compare(hsync == (px < `VIC_HSYNC_END) && vsync == (py < `VIC_VSYNC_END) &&
                 active == in_active(px, py),
                 $sformatf("syncs %b%b%b at x %0d y %0d", hsync, vsync, active, px, py),
                 video_errors);
      end
      snap_border = sh_border;  // used by the next dot_en edge
      snap_bg     = sh_bg;
   end

   initial begin
      int start_cyc;
      int target;
      rst = 1'b1;
      ce  = 1'b1;
      rw  = 1'b1;
      adi = '0;
      dbi = '0;
      apply_reset();

      // random colour and enable writes read back, upper bits fixed
      repeat (8) begin
         bus_write(`VIC_REG_BORDER, rand_bits(8));
         bus_write(`VIC_REG_BG0, rand_bits(8));
         bus_write(`VIC_REG_IRQEN, rand_bits(8));
         read_check(`VIC_REG_BORDER, 1'b0, 1'b0);
         read_check(`VIC_REG_BG0, 1'b0, 1'b0);
         read_check(`VIC_REG_IRQEN, 1'b0, 1'b0);
         read_check(6'h3F, 1'b0, 1'b0);  // unused address
      end
      bus_write(`VIC_REG_IRQEN, 8'h00);

      // line number reads across two frames
      start_cyc = cyc;
      while (cyc - start_cyc < 2 * frame_clocks) begin
         read_check(`VIC_REG_RASTER, 1'b0, 1'b0);
         read_check(`VIC_REG_CTRL, 1'b0, 1'b0);
      end

      // masked compare hit sets the flag only
      target = pick_line();
      set_compare(target);
      while (!(line_y(cyc) == target && dot_x(cyc) > 0)) begin
         @(negedge clk_dot4x);
         compare(irq == 1'b0, "irq rose with the enable low", bus_errors);
      end
      read_check(`VIC_REG_IRQ, 1'b1, 1'b0);

      // enabled hit raises irq one clock into the compare line
      target = pick_line();
      set_compare(target);
      bus_write(`VIC_REG_IRQEN, 8'h01);
      read_check(`VIC_REG_IRQ, 1'b0, 1'b0);
      while (!irq) @(negedge clk_dot4x);
      compare(line_y(cyc) == target && dot_x(cyc) == 0 && cyc % 4 == 1,
              $sformatf("irq rose at line %0d dot %0d, compare line %0d",
                        line_y(cyc), dot_x(cyc), target), bus_errors);
      bus_write(`VIC_REG_IRQ, 8'hFE);  // bit 0 low keeps the flag
      read_check(`VIC_REG_IRQ, 1'b1, 1'b1);
      bus_write(`VIC_REG_IRQ, 8'h01);
      read_check(`VIC_REG_IRQ, 1'b0, 1'b0);

      // reset in the middle of a frame with irq pending
      set_compare(pick_line());
      while (!irq) @(negedge clk_dot4x);
      repeat (3000) @(negedge clk_dot4x);
      apply_reset();
      read_check(`VIC_REG_RASTER, 1'b0, 1'b0);
      read_check(`VIC_REG_IRQ, 1'b0, 1'b0);
      read_check(`VIC_REG_BORDER, 1'b0, 1'b0);
      repeat (4 * `VIC_DOTS_PER_LINE) @(negedge clk_dot4x);  // one line of video checks

      $display("bus errors %0d, video errors %0d", bus_errors, video_errors);
      if (bus_errors == 0 && video_errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== vicii_lite.f ====
+incdir+design
design/vicii_pkg.sv
design/reg_bus.sv
design/raster_timing.sv
design/pixel_out.sv
design/vicii_lite.sv
dv/vicii_lite_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module vicii_lite_tb -f vicii_lite.f -Mdir obj_dir -o vicii_lite_sim &&
./obj_dir/vicii_lite_sim > sim.log 2>&1 &&
cat sim.log &&
grep -q "^TEST OK$" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
